// ==== project.f ====
+incdir+include
src/stream_pkg.sv
src/stream_apb_regs.sv
src/tile_addr_gen.sv
src/feature_bank.sv
src/stream_out_stage.sv
src/stream_buffer.sv
bench/stream_buffer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the feature stream buffer testbench with Verilator and runs it.
# The exit status is 0 only when the simulation prints its pass line.

cd "$(dirname "$0")" || exit 1

SIM_DIR=obj_dir
SIM_BIN=stream_buffer_sim

verilator --binary -f project.f \
	--top-module stream_buffer_tb \
	-Mdir "$SIM_DIR" -o "$SIM_BIN" \
	&& "./$SIM_DIR/$SIM_BIN" | tee /dev/stderr | grep -qF "TEST RESULT: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== bench/stream_buffer_tb.sv ====
`timescale 1ns/1ps
`include "stream_settings.svh"

module stream_buffer_tb;
	import stream_pkg::*;

	localparam int AW = `STREAM_ADDR_W;
	localparam int LANES = `STREAM_LANES;
	localparam int GROUPS = `STREAM_GROUPS;
	localparam int STRIDE = `STREAM_WIN_STRIDE;
	localparam int BEATS_PER_WIN = LANES * GROUPS;
	localparam int LOAD_WORDS = 32; // covers every address of a scan up to 7 windows.
	localparam int LOAD_AW = $clog2(LOAD_WORDS);
	localparam int RESET_CYCLES = 5;
	localparam int FIRST_BEAT_WAIT = 16;
	localparam int SCAN_CYCLES = (3 + 2 + 4 + 1) * BEATS_PER_WIN + 4 * FIRST_BEAT_WAIT;
	localparam int LOAD_CYCLES = 2 * (LOAD_WORDS + 1);
	localparam int APB_CYCLES = 32 * 3;
	localparam int TIMEOUT_CYCLES =
		2 * (RESET_CYCLES + SCAN_CYCLES + LOAD_CYCLES + APB_CYCLES + 24);

	logic clk = 1'b0;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`STREAM_APB_ADDR_W-1:0] paddr;
	logic [`STREAM_APB_DATA_W-1:0] pwdata;
	logic [`STREAM_APB_DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;
	bank_wr_t ddr_wr;
	bank_wr_t pool_wr;
	bank_wr_t eltwise_wr;
	feature_pair_t o_feature;
	logic o_done;

	logic [`STREAM_DATA_W-1:0] model_bank0 [0:LOAD_WORDS-1];
	logic [`STREAM_DATA_W-1:0] model_bank1 [0:LOAD_WORDS-1];
	src_sel_e model_src;
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;

	stream_buffer i_stream_buffer (
		.clk(clk),
		.i_reset(reset),
		.i_psel(psel),
		.i_penable(penable),
		.i_pwrite(pwrite),
		.i_paddr(paddr),
		.i_pwdata(pwdata),
		.o_prdata(prdata),
		.o_pready(pready),
		.o_pslverr(pslverr),
		.i_ddr_wr(ddr_wr),
		.i_pool_wr(pool_wr),
		.i_eltwise_wr(eltwise_wr),
		.o_feature(o_feature),
		.o_done(o_done)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("error: simulation timed out after %0d cycles", cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// each access is one setup cycle and one access cycle with no wait states.
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
			output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#1;
		err = pslverr;
		check_value("o_pready", 32'(pready), 32'd1);
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
			output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#1;
		data = prdata;
		err = pslverr;
		check_value("o_pready", 32'(pready), 32'd1);
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	function automatic logic [31:0] ctrl_word(input logic start);
		return {30'd0, model_src == SRC_ELTWISE, start};
	endfunction

	// all three writers run at once; only the selected one may reach bank 1.
	task automatic load_banks();
		logic [LOAD_AW-1:0] idx;
		for (int i = 0; i < LOAD_WORDS; i++) begin
			@(posedge clk);
			#1;
			idx = LOAD_AW'(i);
			ddr_wr = '{en: 1'b1, addr: AW'(i), data: 16'($urandom())};
			pool_wr = '{en: 1'b1, addr: AW'(i), data: 16'($urandom())};
			eltwise_wr = '{en: 1'b1, addr: AW'(i), data: 16'($urandom())};
			model_bank0[idx] = ddr_wr.data;
			model_bank1[idx] = (model_src == SRC_ELTWISE) ?
				eltwise_wr.data : pool_wr.data;
		end
		@(posedge clk);
		#1;
		ddr_wr.en = 1'b0;
		pool_wr.en = 1'b0;
		eltwise_wr.en = 1'b0;
	endtask

	task automatic start_scan(input int windows);
		logic err;
		apb_write(`STREAM_ADDR_WINDOWS, 32'(windows), err);
		check_value("o_pslverr", 32'(err), 32'd0);
		apb_write(`STREAM_ADDR_CTRL, ctrl_word(1'b1), err);
		check_value("o_pslverr", 32'(err), 32'd0);
	endtask

	// window w, group g, lane l reads address w*stride + g + l, lane fastest.
	task automatic check_stream(input int windows);
		int beats;
		int waited;
		int addr;
		logic [LOAD_AW-1:0] idx;
		beats = windows * BEATS_PER_WIN;
		waited = 0;
		@(posedge clk);
		#2;
		while (!o_feature.valid && waited < FIRST_BEAT_WAIT) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (!o_feature.valid) begin
			errors++;
			$display("error: no output beat within %0d cycles of the start",
				FIRST_BEAT_WAIT);
			return;
		end
		for (int i = 0; i < beats; i++) begin
			addr = (i / BEATS_PER_WIN) * STRIDE + (i / LANES) % GROUPS + i % LANES;
			idx = LOAD_AW'(addr);
			check_value("o_feature.valid", 32'(o_feature.valid), 32'd1);
			check_value("o_feature.f0", 32'(o_feature.f0), 32'(model_bank0[idx]));
			check_value("o_feature.f1", 32'(o_feature.f1), 32'(model_bank1[idx]));
			check_value("o_done", 32'(o_done), 32'(i == beats - 1));
			@(posedge clk);
			#2;
		end
		check_value("o_feature.valid", 32'(o_feature.valid), 32'd0); // one beat too many.
		check_value("o_done", 32'(o_done), 32'd0);
	endtask

	task automatic watch_quiet(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#2;
			check_value("o_feature.valid", 32'(o_feature.valid), 32'd0);
			check_value("o_done", 32'(o_done), 32'd0);
		end
	endtask

	task automatic test_reset_values();
		logic [31:0] data;
		logic err;
		apb_read(`STREAM_ADDR_STATUS, data, err);
		check_value("STATUS", data, 32'd0);
		check_value("o_pslverr", 32'(err), 32'd0);
		apb_read(`STREAM_ADDR_CTRL, data, err);
		check_value("CTRL", data, 32'd0);
		check_value("o_pslverr", 32'(err), 32'd0);
		watch_quiet(8);
	endtask

	task automatic test_register_access();
		logic [31:0] data;
		logic err;
		apb_write(`STREAM_ADDR_WINDOWS, 32'd5, err);
		apb_read(`STREAM_ADDR_WINDOWS, data, err);
		check_value("WINDOWS", data, 32'd5);
		apb_write(`STREAM_ADDR_CTRL, 32'h2, err);
		apb_read(`STREAM_ADDR_CTRL, data, err);
		check_value("CTRL", data, 32'h2);
		apb_write(8'h0C, 32'hffff_ffff, err); // no such register.
		check_value("o_pslverr", 32'(err), 32'd1);
		apb_read(8'h0C, data, err);
		check_value("o_pslverr", 32'(err), 32'd1);
		apb_read(`STREAM_ADDR_WINDOWS, data, err);
		check_value("WINDOWS", data, 32'd5);
		apb_read(`STREAM_ADDR_CTRL, data, err);
		check_value("CTRL", data, 32'h2);
		apb_read(`STREAM_ADDR_STATUS, data, err);
		check_value("STATUS", data, 32'd0);
		model_src = SRC_POOL;
		apb_write(`STREAM_ADDR_CTRL, ctrl_word(1'b0), err);
	endtask

	task automatic test_pool_scan();
		load_banks();
		start_scan(3);
		check_stream(3);
	endtask

	task automatic test_eltwise_scan();
		logic err;
		model_src = SRC_ELTWISE;
		apb_write(`STREAM_ADDR_CTRL, ctrl_word(1'b0), err);
		load_banks();
		start_scan(2);
		check_stream(2);
	endtask

	task automatic test_busy_start();
		logic [31:0] data;
		logic err;
		start_scan(4);
		fork
			check_stream(4);
			begin
				apb_read(`STREAM_ADDR_STATUS, data, err);
				check_value("STATUS", data, 32'h1); // the start cleared the old done.
				apb_write(`STREAM_ADDR_CTRL, ctrl_word(1'b1), err);
				apb_read(`STREAM_ADDR_STATUS, data, err);
				check_value("STATUS", data, 32'h1);
			end
		join
		watch_quiet(16);
		apb_read(`STREAM_ADDR_STATUS, data, err);
		check_value("STATUS", data, 32'h2);
		start_scan(1);
		fork
			check_stream(1);
			begin
				apb_read(`STREAM_ADDR_STATUS, data, err);
				check_value("STATUS", data, 32'h1);
			end
		join
	endtask

	initial begin
		void'($urandom(32'h6158_f5fa));
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		ddr_wr = '0;
		pool_wr = '0;
		eltwise_wr = '0;
		model_src = SRC_POOL;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		test_reset_values();
		test_register_access();
		test_pool_scan();
		test_eltwise_scan();
		test_busy_start();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== src/stream_buffer.sv ====
`timescale 1ns/1ps
`include "stream_settings.svh"

module stream_buffer (
	input logic clk,
	input logic i_reset,
	input logic i_psel,
	input logic i_penable,
	input logic i_pwrite,
	input logic [`STREAM_APB_ADDR_W-1:0] i_paddr,
	input logic [`STREAM_APB_DATA_W-1:0] i_pwdata,
	output logic [`STREAM_APB_DATA_W-1:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr,
	input stream_pkg::bank_wr_t i_ddr_wr,
	input stream_pkg::bank_wr_t i_pool_wr,
	input stream_pkg::bank_wr_t i_eltwise_wr,
	output stream_pkg::feature_pair_t o_feature,
	output logic o_done
);
	import stream_pkg::*;

	logic start;
	logic busy;
	logic [`STREAM_WIN_W-1:0] windows;
	src_sel_e src_sel;
	scan_rd_t scan_rd;
	bank_wr_t bank1_wr;
	logic [`STREAM_DATA_W-1:0] bank0_data;
	logic [`STREAM_DATA_W-1:0] bank1_data;

	stream_apb_regs u_apb_regs (
		.clk(clk),
		.i_reset(i_reset),
		.i_psel(i_psel),
		.i_penable(i_penable),
		.i_pwrite(i_pwrite),
		.i_paddr(i_paddr),
		.i_pwdata(i_pwdata),
		.o_prdata(o_prdata),
		.o_pready(o_pready),
		.o_pslverr(o_pslverr),
		.i_busy(busy),
		.i_done(o_done),
		.o_start(start),
		.o_windows(windows),
		.o_src_sel(src_sel)
	);

	// one scanner drives both banks, so they always read the same address.
	tile_addr_gen u_addr_gen (
		.clk(clk),
		.i_reset(i_reset),
		.i_start(start),
		.i_windows(windows),
		.o_rd(scan_rd),
		.o_busy(busy)
	);

	assign bank1_wr = (src_sel == SRC_ELTWISE) ? i_eltwise_wr : i_pool_wr;

	feature_bank u_bank0 (
		.clk(clk),
		.i_wr(i_ddr_wr),
		.i_rd_addr(scan_rd.addr),
		.o_rd_data(bank0_data)
	);

	feature_bank u_bank1 (
		.clk(clk),
		.i_wr(bank1_wr),
		.i_rd_addr(scan_rd.addr),
		.o_rd_data(bank1_data)
	);

	stream_out_stage u_out_stage (
		.clk(clk),
		.i_reset(i_reset),
		.i_rd(scan_rd),
		.i_f0(bank0_data),
		.i_f1(bank1_data),
		.o_feature(o_feature),
		.o_done(o_done)
	);

endmodule

// ==== src/stream_out_stage.sv ====
`timescale 1ns/1ps
`include "stream_settings.svh"

module stream_out_stage (
	input logic clk,
	input logic i_reset,
	input stream_pkg::scan_rd_t i_rd,
	input logic [`STREAM_DATA_W-1:0] i_f0,
	input logic [`STREAM_DATA_W-1:0] i_f1,
	output stream_pkg::feature_pair_t o_feature,
	output logic o_done
);
	localparam int LAT = `STREAM_RD_LAT;

	logic [LAT-1:0] valid_sr;
	logic [LAT-1:0] last_sr;

	// the flags travel alongside the bank read pipeline.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_sr <= '0;
			last_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[LAT-2:0], i_rd.valid};
			last_sr <= {last_sr[LAT-2:0], i_rd.last};
		end
	end

	always_comb begin
		o_feature.valid = valid_sr[LAT-1];
		o_feature.f0 = i_f0;
		o_feature.f1 = i_f1;
	end

	assign o_done = last_sr[LAT-1]; // high with the final beat only.

endmodule

// ==== src/feature_bank.sv ====
`timescale 1ns/1ps
`include "stream_settings.svh"

module feature_bank (
	input logic clk,
	input stream_pkg::bank_wr_t i_wr,
	input logic [`STREAM_ADDR_W-1:0] i_rd_addr,
	output logic [`STREAM_DATA_W-1:0] o_rd_data
);
	localparam int AW = `STREAM_ADDR_W;
	localparam int DW = `STREAM_DATA_W;
	localparam int DEPTH = `STREAM_BANK_DEPTH;

	logic [DW-1:0] mem [0:DEPTH-1];
	logic [AW-1:0] rd_addr_q;
	logic [DW-1:0] rd_data_q;

	// external writer port.
	always_ff @(posedge clk) begin
		if (i_wr.en) begin
			mem[i_wr.addr] <= i_wr.data;
		end
	end

	// address register, memory read, output register.
	// data for an address presented in cycle k shows up in cycle k+3.
	always_ff @(posedge clk) begin
		rd_addr_q <= i_rd_addr;
		rd_data_q <= mem[rd_addr_q];
		o_rd_data <= rd_data_q;
	end

endmodule

// ==== src/tile_addr_gen.sv ====
`timescale 1ns/1ps
`include "stream_settings.svh"

module tile_addr_gen (
	input logic clk,
	input logic i_reset,
	input logic i_start,
	input logic [`STREAM_WIN_W-1:0] i_windows,
	output stream_pkg::scan_rd_t o_rd,
	output logic o_busy
);
	import stream_pkg::*;

	localparam int AW = `STREAM_ADDR_W;
	localparam int WW = `STREAM_WIN_W;
	localparam int LANE_W = $clog2(`STREAM_LANES);
	localparam int GRP_W = $clog2(`STREAM_GROUPS);
	localparam logic [LANE_W-1:0] LANE_END = LANE_W'(`STREAM_LANES - 1);
	localparam logic [GRP_W-1:0] GRP_END = GRP_W'(`STREAM_GROUPS - 1);

	scan_state_e state;
	logic [LANE_W-1:0] lane;
	logic [GRP_W-1:0] grp;
	logic [WW-1:0] win;
	logic [WW-1:0] win_end;
	logic [AW-1:0] base; // first word of the current window.
	logic lane_wrap;
	logic grp_wrap;
	logic win_wrap;

	assign lane_wrap = (lane == LANE_END);
	assign grp_wrap = lane_wrap && (grp == GRP_END);
	assign win_wrap = grp_wrap && (win == win_end);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= SCAN_IDLE;
			lane <= '0;
			grp <= '0;
			win <= '0;
			win_end <= '0;
			base <= '0;
		end else begin
			unique case (state)
				SCAN_IDLE: begin
					if (i_start) begin
						state <= SCAN_RUN;
						lane <= '0;
						grp <= '0;
						win <= '0;
						base <= '0;
						// a window count of zero runs a single window.
						win_end <= (i_windows == '0) ? '0 : i_windows - 1'b1;
					end
				end
				SCAN_RUN: begin
					lane <= lane_wrap ? '0 : lane + 1'b1;
					if (lane_wrap) begin
						grp <= grp_wrap ? '0 : grp + 1'b1;
					end
					if (grp_wrap) begin
						if (win_wrap) begin
							state <= SCAN_IDLE;
						end else begin
							win <= win + 1'b1;
							base <= base + AW'(`STREAM_WIN_STRIDE);
						end
					end
				end
				default: state <= SCAN_IDLE;
			endcase
		end
	end

	assign o_busy = (state == SCAN_RUN);

	// group g starts one word further on, lanes then walk consecutive words.
	always_comb begin
		o_rd.valid = o_busy;
		o_rd.addr = base + AW'(grp) + AW'(lane);
		o_rd.last = o_busy && win_wrap;
	end

endmodule

// ==== src/stream_apb_regs.sv ====
`timescale 1ns/1ps
`include "stream_settings.svh"

module stream_apb_regs (
	input logic clk,
	input logic i_reset,
	input logic i_psel,
	input logic i_penable,
	input logic i_pwrite,
	input logic [`STREAM_APB_ADDR_W-1:0] i_paddr,
	input logic [`STREAM_APB_DATA_W-1:0] i_pwdata,
	output logic [`STREAM_APB_DATA_W-1:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr,
	input logic i_busy,
	input logic i_done,
	output logic o_start,
	output logic [`STREAM_WIN_W-1:0] o_windows,
	output stream_pkg::src_sel_e o_src_sel
);
	import stream_pkg::*;

	localparam int WW = `STREAM_WIN_W;

	logic access;
	logic wr_access;
	logic hit_ctrl;
	logic hit_windows;
	logic hit_status;
	logic start_req;
	logic done_q;

	assign access = i_psel && i_penable; // access phase only.
	assign wr_access = access && i_pwrite;

	assign hit_ctrl = (i_paddr == `STREAM_ADDR_CTRL);
	assign hit_windows = (i_paddr == `STREAM_ADDR_WINDOWS);
	assign hit_status = (i_paddr == `STREAM_ADDR_STATUS);

	assign o_pready = 1'b1;
	assign o_pslverr = access && !(hit_ctrl || hit_windows || hit_status);

	// a start that arrives while a scan runs, or right behind another start, is dropped.
	assign start_req = wr_access && hit_ctrl && i_pwdata[0] && !i_busy && !o_start;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_start <= 1'b0;
		end else begin
			o_start <= start_req;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_windows <= WW'(1);
			o_src_sel <= SRC_POOL;
		end else if (wr_access) begin
			if (hit_ctrl) begin
				o_src_sel <= src_sel_e'(i_pwdata[1]);
			end
			if (hit_windows) begin
				o_windows <= i_pwdata[WW-1:0];
			end
		end
	end

	// sticky done, cleared by the start that begins the next scan.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			done_q <= 1'b0;
		end else if (start_req) begin
			done_q <= 1'b0;
		end else if (i_done) begin
			done_q <= 1'b1;
		end
	end

	always_comb begin
		o_prdata = '0;
		if (hit_ctrl) begin
			o_prdata[1] = (o_src_sel == SRC_ELTWISE); // bit 0 is a pulse and reads as 0.
		end else if (hit_windows) begin
			o_prdata[WW-1:0] = o_windows;
		end else if (hit_status) begin
			o_prdata[0] = i_busy;
			o_prdata[1] = done_q;
		end
	end

endmodule

// ==== src/stream_pkg.sv ====
`include "stream_settings.svh"

package stream_pkg;

	// one write into a feature bank.
	typedef struct packed {
		logic en;
		logic [`STREAM_ADDR_W-1:0] addr;
		logic [`STREAM_DATA_W-1:0] data;
	} bank_wr_t;

	// one read issued by the tile scanner to both banks.
	typedef struct packed {
		logic valid;
		logic [`STREAM_ADDR_W-1:0] addr;
		logic last; // final address of the scan.
	} scan_rd_t;

	// one output beat towards the convolution array.
	typedef struct packed {
		logic valid;
		logic [`STREAM_DATA_W-1:0] f0; // from bank 0.
		logic [`STREAM_DATA_W-1:0] f1; // from bank 1.
	} feature_pair_t;

	typedef enum logic {
		SCAN_IDLE,
		SCAN_RUN
	} scan_state_e;

	// the value of CTRL bit 1 selects the writer of bank 1.
	typedef enum logic {
		SRC_POOL = 1'b0,
		SRC_ELTWISE = 1'b1
	} src_sel_e;

endpackage

// ==== include/stream_settings.svh ====
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// feature word width and bank geometry.
`define STREAM_DATA_W 16
`define STREAM_ADDR_W 14
`define STREAM_BANK_DEPTH 12100

// sliding-window scan order: lanes within a group, groups within a window.
`define STREAM_LANES 4
`define STREAM_GROUPS 2
`define STREAM_WIN_STRIDE 4 // words between the starts of two windows.
`define STREAM_WIN_W 12 // wide enough for every window start inside the bank.

// cycles from a scan address to its data at the bank output.
`define STREAM_RD_LAT 3

// APB bus and register map.
`define STREAM_APB_ADDR_W 8
`define STREAM_APB_DATA_W 32
`define STREAM_ADDR_CTRL 8'h00
`define STREAM_ADDR_WINDOWS 8'h04
`define STREAM_ADDR_STATUS 8'h08

`endif
